// ==== design/egress_pkg.sv ====
/* Egress router package
   Sizes, vector types and the serializer state encoding */

package egress_pkg;

    //////////////////////////////////////////////////
    // Sizes

    localparam int NUM_PORTS     = 3;
    localparam int IN_BYTES      = 4;
    localparam int BUF_WORDS     = 32;
    // Largest packet in words, also the free space needed to admit one
    localparam int MAX_PKT_WORDS = 16;
    localparam int CNT_WIDTH     = 16;
    localparam int BUF_PTR_WIDTH = $clog2(BUF_WORDS);

    //////////////////////////////////////////////////
    // Types

    typedef logic [1:0]               port_idx_t;
    // Byte 0 sits in the low bits and leaves first
    typedef logic [IN_BYTES*8-1:0]    word_t;
    typedef logic [2:0]               byte_cnt_t;
    typedef logic [7:0]               byte_t;
    typedef logic [NUM_PORTS-1:0]     port_mask_t;
    typedef logic [CNT_WIDTH-1:0]     cnt_t;
    typedef logic [BUF_PTR_WIDTH-1:0] buf_ptr_t;
    // One extra bit so a full buffer is distinct from an empty one
    typedef logic [BUF_PTR_WIDTH:0]   buf_lvl_t;

    typedef enum logic [0:0] {
        IDLE,
        SHIFT
    } ser_state_t;

endpackage

// ==== design/egress_port_demux.sv ====
/* Egress port demux
   Steers each input packet to its destination port, or drops it when the port is disabled */

`timescale 1ns/1ps

module egress_port_demux
    import egress_pkg::*;
(
    input  logic       core_clk_ifc,
    input  logic       rst_n,
    input  logic       in_valid,
    input  word_t      in_data,
    input  byte_cnt_t  in_bytes,
    input  logic       in_last,
    input  port_idx_t  in_port,
    input  port_mask_t port_enable,
    output port_mask_t route_valid,
    output word_t      route_data,
    output byte_cnt_t  route_bytes,
    output logic       route_last,
    output logic       route_first
);

    logic      in_pkt;
    port_idx_t cur_port;
    logic      cur_en;
    port_idx_t sel_port;
    logic      sel_en;

    // Destination and enable come from the first word, later words reuse the latched copy
    always_comb begin
        sel_port = in_pkt ? cur_port : in_port;
        sel_en   = in_pkt ? cur_en : ((in_port < NUM_PORTS) && port_enable[in_port]);
    end

    always_ff @(posedge core_clk_ifc) begin
        if (!rst_n) begin
            in_pkt      <= 1'b0;
            cur_port    <= '0;
            cur_en      <= 1'b0;
            route_valid <= '0;
            route_first <= 1'b0;
            route_last  <= 1'b0;
        end else begin
            route_valid <= '0;
            route_first <= 1'b0;
            route_last  <= 1'b0;
            if (in_valid) begin
                in_pkt   <= !in_last;
                cur_port <= sel_port;
                cur_en   <= sel_en;
                if (sel_en) begin
                    route_valid <= port_mask_t'(1) << sel_port;
                end
                route_first <= !in_pkt;
                route_last  <= in_last;
            end
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        if (in_valid) begin
            route_data  <= in_data;
            route_bytes <= in_bytes;
        end
    end

endmodule

// ==== design/egress_port_buffer.sv ====
/* Egress port buffer
   Word FIFO that admits or drops whole packets depending on free space at the first word */

`timescale 1ns/1ps

module egress_port_buffer
    import egress_pkg::*;
(
    input  logic      core_clk_ifc,
    input  logic      rst_n,
    input  logic      wr_valid,
    input  logic      wr_first,
    input  logic      wr_last,
    input  word_t     wr_data,
    input  byte_cnt_t wr_bytes,
    input  logic      buf_pop,
    output logic      buf_valid,
    output logic      buf_last,
    output word_t     buf_data,
    output byte_cnt_t buf_bytes,
    output logic      buf_full_drop
);

    word_t     data_mem  [BUF_WORDS];
    byte_cnt_t bytes_mem [BUF_WORDS];
    logic      last_mem  [BUF_WORDS];

    buf_ptr_t wr_ptr;
    buf_ptr_t rd_ptr;
    buf_lvl_t level;
    logic     admit_q;
    logic     space_ok;
    logic     admit;
    logic     push;
    logic     pop;

    //////////////////////////////////////////////////
    // Admission

    // Room for a full-size packet is required, whatever this one's length
    assign space_ok = level <= buf_lvl_t'(BUF_WORDS - MAX_PKT_WORDS);
    assign admit    = wr_first ? space_ok : admit_q;
    assign push     = wr_valid && admit;
    assign pop      = buf_pop && buf_valid;

    assign buf_full_drop = wr_valid && wr_first && !space_ok;

    //////////////////////////////////////////////////
    // Pointers and fill level

    always_ff @(posedge core_clk_ifc) begin
        if (!rst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            level   <= '0;
            admit_q <= 1'b0;
        end else begin
            // Decision holds until the last word, then words without a first are dropped
            if (wr_valid && wr_last) begin
                admit_q <= 1'b0;
            end else if (wr_valid && wr_first) begin
                admit_q <= space_ok;
            end
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Storage

    always_ff @(posedge core_clk_ifc) begin
        if (push) begin
            data_mem[wr_ptr]  <= wr_data;
            bytes_mem[wr_ptr] <= wr_bytes;
            last_mem[wr_ptr]  <= wr_last;
        end
    end

    assign buf_valid = level != '0;
    assign buf_data  = data_mem[rd_ptr];
    assign buf_bytes = bytes_mem[rd_ptr];
    assign buf_last  = last_mem[rd_ptr];

endmodule

// ==== design/egress_byte_serializer.sv ====
/* Egress byte serializer
   Unpacks buffered words into one byte per cycle, low byte first */

`timescale 1ns/1ps

module egress_byte_serializer
    import egress_pkg::*;
(
    input  logic      core_clk_ifc,
    input  logic      rst_n,
    input  logic      buf_valid,
    input  logic      buf_last,
    input  word_t     buf_data,
    input  byte_cnt_t buf_bytes,
    output logic      buf_pop,
    output logic      egr_valid,
    output logic      egr_last,
    output byte_t     egr_data
);

    ser_state_t state;
    word_t      shift_q;
    byte_cnt_t  rem_q;
    logic       last_q;
    logic       final_byte;
    byte_cnt_t  load_bytes;

    assign final_byte = (state == SHIFT) && (rem_q == byte_cnt_t'(1));
    // Next word is taken on the final byte so the port never idles between words
    assign buf_pop    = buf_valid && ((state == IDLE) || final_byte);

    // Out of range counts are treated as a full word
    assign load_bytes = ((buf_bytes == '0) || (buf_bytes > IN_BYTES)) ?
                        byte_cnt_t'(IN_BYTES) : buf_bytes;

    assign egr_valid = (state == SHIFT);
    assign egr_data  = shift_q[7:0];
    assign egr_last  = final_byte && last_q;

    always_ff @(posedge core_clk_ifc) begin
        if (!rst_n) begin
            state <= IDLE;
            rem_q <= '0;
        end else if (buf_pop) begin
            state <= SHIFT;
            rem_q <= load_bytes;
        end else if (state == SHIFT) begin
            if (final_byte) begin
                state <= IDLE;
            end
            rem_q <= rem_q - 1'b1;
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        if (buf_pop) begin
            shift_q <= buf_data;
            last_q  <= buf_last;
        end else if (state == SHIFT) begin
            shift_q <= shift_q >> 8;
        end
    end

endmodule

// ==== design/egress_frame_counters.sv ====
/* Egress frame counters
   Per-port delivered frame and dropped packet counts with synchronous clear */

`timescale 1ns/1ps

module egress_frame_counters
    import egress_pkg::*;
(
    input  logic       core_clk_ifc,
    input  logic       rst_n,
    input  port_mask_t egr_last,
    input  port_mask_t egr_valid,
    input  port_mask_t buf_full_drop,
    input  port_mask_t egr_cnts_clear,
    output cnt_t       egr_frame_cnt [NUM_PORTS-1:0],
    output cnt_t       egr_drop_cnt  [NUM_PORTS-1:0]
);

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port

        // Clear wins over a same-cycle increment, counts wrap at full scale
        always_ff @(posedge core_clk_ifc) begin
            if (!rst_n) begin
                egr_frame_cnt[p] <= '0;
                egr_drop_cnt[p]  <= '0;
            end else if (egr_cnts_clear[p]) begin
                egr_frame_cnt[p] <= '0;
                egr_drop_cnt[p]  <= '0;
            end else begin
                if (egr_valid[p] && egr_last[p]) begin
                    egr_frame_cnt[p] <= egr_frame_cnt[p] + 1'b1;
                end
                if (buf_full_drop[p]) begin
                    egr_drop_cnt[p] <= egr_drop_cnt[p] + 1'b1;
                end
            end
        end

    end

endmodule

// ==== design/egress_router_top.sv ====
/* Egress router top
   Demux feeding one buffer and byte serializer per port, plus the frame counters */

`timescale 1ns/1ps

module egress_router_top
    import egress_pkg::*;
(
    input  logic       core_clk_ifc,
    input  logic       rst_n,
    input  logic       in_valid,
    input  word_t      in_data,
    input  byte_cnt_t  in_bytes,
    input  logic       in_last,
    input  port_idx_t  in_port,
    input  port_mask_t egr_phys_ports_enable,
    input  port_mask_t egr_cnts_clear,
    output port_mask_t egr_valid,
    output byte_t      egr_data [NUM_PORTS-1:0],
    output port_mask_t egr_last,
    output port_mask_t egr_buf_full_drop,
    output cnt_t       egr_frame_cnt [NUM_PORTS-1:0],
    output cnt_t       egr_drop_cnt  [NUM_PORTS-1:0]
);

    port_mask_t route_valid;
    word_t      route_data;
    byte_cnt_t  route_bytes;
    logic       route_last;
    logic       route_first;

    port_mask_t buf_valid;
    port_mask_t buf_last;
    port_mask_t buf_pop;
    word_t      buf_data  [NUM_PORTS-1:0];
    byte_cnt_t  buf_bytes [NUM_PORTS-1:0];

    egress_port_demux u_demux (
        .core_clk_ifc (core_clk_ifc),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_data      (in_data),
        .in_bytes     (in_bytes),
        .in_last      (in_last),
        .in_port      (in_port),
        .port_enable  (egr_phys_ports_enable),
        .route_valid  (route_valid),
        .route_data   (route_data),
        .route_bytes  (route_bytes),
        .route_last   (route_last),
        .route_first  (route_first)
    );

    //////////////////////////////////////////////////
    // Per-port lanes

    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_lane
        egress_port_buffer u_buffer (
            .core_clk_ifc  (core_clk_ifc),
            .rst_n         (rst_n),
            .wr_valid      (route_valid[i]),
            .wr_first      (route_first),
            .wr_last       (route_last),
            .wr_data       (route_data),
            .wr_bytes      (route_bytes),
            .buf_pop       (buf_pop[i]),
            .buf_valid     (buf_valid[i]),
            .buf_last      (buf_last[i]),
            .buf_data      (buf_data[i]),
            .buf_bytes     (buf_bytes[i]),
            .buf_full_drop (egr_buf_full_drop[i])
        );

        egress_byte_serializer u_serializer (
            .core_clk_ifc (core_clk_ifc),
            .rst_n        (rst_n),
            .buf_valid    (buf_valid[i]),
            .buf_last     (buf_last[i]),
            .buf_data     (buf_data[i]),
            .buf_bytes    (buf_bytes[i]),
            .buf_pop      (buf_pop[i]),
            .egr_valid    (egr_valid[i]),
            .egr_last     (egr_last[i]),
            .egr_data     (egr_data[i])
        );
    end

    egress_frame_counters u_counters (
        .core_clk_ifc   (core_clk_ifc),
        .rst_n          (rst_n),
        .egr_last       (egr_last),
        .egr_valid      (egr_valid),
        .buf_full_drop  (egr_buf_full_drop),
        .egr_cnts_clear (egr_cnts_clear),
        .egr_frame_cnt  (egr_frame_cnt),
        .egr_drop_cnt   (egr_drop_cnt)
    );

endmodule

// ==== dv/egress_clk_gen.sv ====
/* Testbench clock and reset
   100 ns clock, active low reset held for two cycles */

`timescale 1ns/1ps

module egress_clk_gen (
    output logic core_clk_ifc,
    output logic rst_n
);

    localparam int HALF_PERIOD_NS = 50;

    initial begin
        core_clk_ifc = 1'b0;
        forever #(HALF_PERIOD_NS) core_clk_ifc = ~core_clk_ifc;
    end

    // Release on a falling edge, in step with the stimulus
    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge core_clk_ifc);
        @(negedge core_clk_ifc);
        rst_n = 1'b1;
    end

endmodule

// ==== dv/egress_router_checker.sv ====
/* Egress router output checker
   Concurrent assertions on the egress strobes, bound into the router top */

`timescale 1ns/1ps

module egress_router_checker
    import egress_pkg::*;
(
    input logic       core_clk_ifc,
    input logic       rst_n,
    input port_mask_t egr_valid,
    input port_mask_t egr_last,
    input port_mask_t egr_buf_full_drop
);

    logic reset_held;

    // High once reset has covered a full clock edge
    always_ff @(posedge core_clk_ifc) begin
        reset_held <= !rst_n;
    end

    // A last marker always rides on a valid byte
    last_needs_valid: assert property (
        @(posedge core_clk_ifc) disable iff (!rst_n)
        (egr_last & ~egr_valid) == '0
    ) else $error("egr_last set on a port without egr_valid");

    quiet_in_reset: assert property (
        @(posedge core_clk_ifc)
        (!rst_n && reset_held) |->
            (egr_valid == '0 && egr_last == '0 && egr_buf_full_drop == '0)
    ) else $error("egress strobe active during reset");

    // Only one port can see a first word per cycle
    one_drop_per_cycle: assert property (
        @(posedge core_clk_ifc) disable iff (!rst_n)
        $onehot0(egr_buf_full_drop)
    ) else $error("more than one drop strobe in the same cycle");

endmodule

bind egress_router_top egress_router_checker u_checker (
    .core_clk_ifc      (core_clk_ifc),
    .rst_n             (rst_n),
    .egr_valid         (egr_valid),
    .egr_last          (egr_last),
    .egr_buf_full_drop (egr_buf_full_drop)
);

// ==== dv/egress_router_tb.sv ====
/* Egress router testbench
   Table-driven packets with a per-port byte scoreboard, counter checks and a watchdog */

`timescale 1ns/1ps

module egress_router_tb
    import egress_pkg::*;
();

    typedef struct packed {
        port_mask_t enable;
        logic       one_port;
        port_idx_t  port;
        int         pkts;
        int         len;
        int         gap;
        logic       expect_drop;
    } test_row_t;

    localparam int NUM_TESTS   = 5;
    localparam int IDLE_CYCLES = 8;

    logic       core_clk_ifc;
    logic       rst_n;
    logic       in_valid;
    word_t      in_data;
    byte_cnt_t  in_bytes;
    logic       in_last;
    port_idx_t  in_port;
    port_mask_t egr_phys_ports_enable;
    port_mask_t egr_cnts_clear;
    port_mask_t egr_valid;
    byte_t      egr_data [NUM_PORTS-1:0];
    port_mask_t egr_last;
    port_mask_t egr_buf_full_drop;
    cnt_t       egr_frame_cnt [NUM_PORTS-1:0];
    cnt_t       egr_drop_cnt  [NUM_PORTS-1:0];

    test_row_t   tests [NUM_TESTS];
    string       test_names [NUM_TESTS];
    logic        table_ready;
    logic        verdict_given;
    int          errors;
    int          checks;
    int          cur_len;
    logic        in_pkt;
    // Expected packets per port as length << 8 | start byte
    int unsigned exp_q [NUM_PORTS][$];
    int          rx_idx    [NUM_PORTS];
    int          delivered [NUM_PORTS];
    int          dropped   [NUM_PORTS];

    egress_clk_gen u_clk_gen (
        .core_clk_ifc (core_clk_ifc),
        .rst_n        (rst_n)
    );

    egress_router_top u_egress_router_top (
        .core_clk_ifc          (core_clk_ifc),
        .rst_n                 (rst_n),
        .in_valid              (in_valid),
        .in_data               (in_data),
        .in_bytes              (in_bytes),
        .in_last               (in_last),
        .in_port               (in_port),
        .egr_phys_ports_enable (egr_phys_ports_enable),
        .egr_cnts_clear        (egr_cnts_clear),
        .egr_valid             (egr_valid),
        .egr_data              (egr_data),
        .egr_last              (egr_last),
        .egr_buf_full_drop     (egr_buf_full_drop),
        .egr_frame_cnt         (egr_frame_cnt),
        .egr_drop_cnt          (egr_drop_cnt)
    );

    //////////////////////////////////////////////////
    // Compare and report

    task automatic compare_byte(input byte_t got, input byte_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s got %02h expected %02h", $time, what, got, exp);
        end
    endtask

    task automatic compare_cnt(input cnt_t got, input cnt_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic compare_mask(input port_mask_t got, input port_mask_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("ERROR at %0t: %s", $time, msg);
    endtask

    //////////////////////////////////////////////////
    // Scoreboard

    // Log each packet that starts on an enabled port
    always @(posedge core_clk_ifc) begin
        if (!rst_n) begin
            in_pkt <= 1'b0;
        end else if (in_valid) begin
            if (!in_pkt && egr_phys_ports_enable[in_port]) begin
                exp_q[in_port].push_back((cur_len << 8) | int'(in_data[7:0]));
            end
            in_pkt <= !in_last;
        end
    end

    always @(negedge core_clk_ifc) begin : scoreboard
        port_mask_t  exp_last;
        int unsigned head;
        if (rst_n) begin
            exp_last = '0;
            for (int p = 0; p < NUM_PORTS; p++) begin
                // A refused packet is always the newest one on its port
                if (egr_buf_full_drop[p]) begin
                    if (exp_q[p].size() == 0) begin
                        report_error($sformatf("drop strobe on port %0d, no packet pending", p));
                    end else begin
                        void'(exp_q[p].pop_back());
                        dropped[p]++;
                    end
                end
                if (egr_valid[p]) begin
                    if (exp_q[p].size() == 0) begin
                        report_error($sformatf("byte on port %0d, no packet expected", p));
                    end else begin
                        head = exp_q[p][0];
                        compare_byte(egr_data[p], byte_t'(head[7:0] + rx_idx[p]),
                                     $sformatf("port %0d byte %0d", p, rx_idx[p]));
                        if (rx_idx[p] == int'(head >> 8) - 1) begin
                            exp_last[p] = 1'b1;
                            void'(exp_q[p].pop_front());
                            delivered[p]++;
                            rx_idx[p] = 0;
                        end else begin
                            rx_idx[p]++;
                        end
                    end
                end
            end
            compare_mask(egr_last, exp_last, "egr_last");
        end
    end

    //////////////////////////////////////////////////
    // Stimulus

    task automatic load_tests();
        // enable, one port, port, packets, length (0 random), gap, drops expected
        tests[0] = '{3'b111, 1'b0, 2'd0, 12, 0, 80, 1'b0};
        tests[1] = '{3'b000, 1'b0, 2'd0, 6, 0, 20, 1'b0};
        tests[2] = '{3'b101, 1'b0, 2'd0, 9, 0, 40, 1'b0};
        tests[3] = '{3'b111, 1'b1, 2'd0, 20, 64, 0, 1'b1};
        tests[4] = '{3'b111, 1'b1, 2'd0, 10, 64, 80, 1'b0};
        test_names[0] = "round-robin delivery";
        test_names[1] = "all ports disabled";
        test_names[2] = "port 1 disabled";
        test_names[3] = "forced drop";
        test_names[4] = "recovery after drop";
    endtask

    function automatic int run_limit_cycles();
        int total;
        total = 0;
        // Per packet at most 16 words in, the gap and 64 bytes out
        for (int t = 0; t < NUM_TESTS; t++) begin
            total += tests[t].pkts * (MAX_PKT_WORDS + tests[t].gap + MAX_PKT_WORDS * IN_BYTES);
            total += 100;
        end
        return total + 200;
    endfunction

    // Number of packets a row sends to port p while its enable bit is set
    function automatic int row_port_pkts(input int t, input int p);
        if (!tests[t].enable[p]) begin
            return 0;
        end
        if (tests[t].one_port) begin
            return (p == int'(tests[t].port)) ? tests[t].pkts : 0;
        end
        return (tests[t].pkts + NUM_PORTS - 1 - p) / NUM_PORTS;
    endfunction

    task automatic send_packet(input port_idx_t port, input int len);
        int    words;
        int    rem;
        byte_t start;
        words = (len + IN_BYTES - 1) / IN_BYTES;
        start = byte_t'($urandom());
        for (int w = 0; w < words; w++) begin
            @(negedge core_clk_ifc);
            rem      = len - w * IN_BYTES;
            in_valid = 1'b1;
            in_port  = port;
            in_last  = (w == words - 1);
            in_bytes = byte_cnt_t'((rem > IN_BYTES) ? IN_BYTES : rem);
            cur_len  = len;
            for (int b = 0; b < IN_BYTES; b++) begin
                in_data[b*8 +: 8] = (b < rem) ? byte_t'(start + w * IN_BYTES + b) : 8'h00;
            end
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge core_clk_ifc);
            in_valid = 1'b0;
            in_last  = 1'b0;
        end
    endtask

    task automatic wait_outputs_idle();
        int quiet;
        quiet = 0;
        while (quiet < IDLE_CYCLES) begin
            @(negedge core_clk_ifc);
            quiet = (egr_valid == '0 && egr_buf_full_drop == '0) ? quiet + 1 : 0;
        end
    endtask

    task automatic check_row(input int t);
        int total_drops;
        int sent_pkts;
        total_drops = 0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            sent_pkts = row_port_pkts(t, p);
            if (exp_q[p].size() != 0) begin
                report_error($sformatf("%0d packets never delivered on port %0d",
                                       exp_q[p].size(), p));
                exp_q[p].delete();
            end
            compare_cnt(egr_frame_cnt[p], cnt_t'(delivered[p]), $sformatf("frame count %0d", p));
            compare_cnt(egr_drop_cnt[p], cnt_t'(dropped[p]), $sformatf("drop count %0d", p));
            if (delivered[p] + dropped[p] != sent_pkts) begin
                report_error($sformatf("port %0d accounts for %0d packets, %0d were sent",
                                       p, delivered[p] + dropped[p], sent_pkts));
            end
            total_drops += dropped[p];
        end
        if (tests[t].expect_drop && total_drops == 0) begin
            report_error("no drop strobe although the buffer should overflow");
        end
        if (!tests[t].expect_drop && total_drops != 0) begin
            report_error($sformatf("%0d packets dropped where none should be", total_drops));
        end
    endtask

    task automatic clear_counters();
        @(negedge core_clk_ifc);
        egr_cnts_clear = '1;
        @(negedge core_clk_ifc);
        egr_cnts_clear = '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            compare_cnt(egr_frame_cnt[p], '0, $sformatf("cleared frame count %0d", p));
            compare_cnt(egr_drop_cnt[p], '0, $sformatf("cleared drop count %0d", p));
            delivered[p] = 0;
            dropped[p]   = 0;
            rx_idx[p]    = 0;
        end
    endtask

    task automatic run_test(input int t);
        int        errs_before;
        int        len;
        port_idx_t port;
        errs_before = errors;
        egr_phys_ports_enable = tests[t].enable;
        for (int i = 0; i < tests[t].pkts; i++) begin
            port = tests[t].one_port ? tests[t].port : port_idx_t'(i % NUM_PORTS);
            len  = (tests[t].len == 0) ? 4 + int'($urandom_range(60)) : tests[t].len;
            send_packet(port, len);
            idle_cycles(tests[t].gap);
        end
        idle_cycles(1);
        wait_outputs_idle();
        check_row(t);
        clear_counters();
        $display("Test %0d %s: %0d errors", t + 1, test_names[t], errors - errs_before);
    endtask

    //////////////////////////////////////////////////
    // Main sequence and watchdog

    initial begin
        in_valid              = 1'b0;
        in_data               = '0;
        in_bytes              = '0;
        in_last               = 1'b0;
        in_port               = '0;
        egr_phys_ports_enable = '0;
        egr_cnts_clear        = '0;
        errors                = 0;
        checks                = 0;
        cur_len               = 0;
        verdict_given         = 1'b0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            rx_idx[p]    = 0;
            delivered[p] = 0;
            dropped[p]   = 0;
        end
        void'($urandom(97599));
        load_tests();
        table_ready = 1'b1;
        wait (rst_n === 1'b1);
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        $display("Summary: %0d tests, %0d checks, %0d errors", NUM_TESTS, checks, errors);
        verdict_given = 1'b1;
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        int limit;
        wait (table_ready === 1'b1);
        limit = run_limit_cycles();
        repeat (limit) @(posedge core_clk_ifc);
        $display("Watchdog: run did not finish within %0d cycles", limit);
        verdict_given = 1'b1;
        $display("TESTS FAILED");
        $finish;
    end

    final begin
        if (!verdict_given) begin
            $display("TESTS FAILED");
        end
    end

endmodule

// ==== src.f ====
design/egress_pkg.sv
design/egress_port_demux.sv
design/egress_port_buffer.sv
design/egress_byte_serializer.sv
design/egress_frame_counters.sv
design/egress_router_top.sv
dv/egress_clk_gen.sv
dv/egress_router_checker.sv
dv/egress_router_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the egress router testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f src.f \
    --top-module egress_router_tb --Mdir "$BUILD_DIR" -o egress_router_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/egress_router_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
    exit 1
fi
exit 0
